// File: logic/imuldiv_settings.svh
// ----------------------------
// muldiv settings
// widths and queue depth for the iterative mul/div subsystem
// ----------------------------

`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// operand width
`define IMULDIV_XLEN 32

// full product, or {remainder, quotient}
`define IMULDIV_RLEN (2 * `IMULDIV_XLEN)

// step counter, wide enough for XLEN steps
`define IMULDIV_CNT_W 5

// one entry per unit is enough
`define IMULDIV_ORDER_DEPTH 2

`endif

// File: logic/imuldiv_pkg.sv
// ----------------------------
// muldiv types
// operand, result, function code and unit state definitions
// ----------------------------

`default_nettype none

`include "imuldiv_settings.svh"

package imuldiv_pkg;

  // ----------------------------
  // data widths
  // ----------------------------
  typedef logic [`IMULDIV_XLEN-1:0] operand_t;
  typedef logic [`IMULDIV_RLEN-1:0] result_t;

  // iteration counter inside a unit
  typedef logic [`IMULDIV_CNT_W-1:0] step_cnt_t;

  // ----------------------------
  // function codes
  // ----------------------------
  typedef logic [1:0] fn_t;

  localparam fn_t FN_MUL  = 2'd0;
  localparam fn_t FN_DIV  = 2'd1;
  // code 3 is reserved and behaves as unsigned divide
  localparam fn_t FN_DIVU = 2'd2;

  // shared by the multiplier and the divider
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } unit_state_t;

endpackage

`default_nettype wire

// File: logic/imuldiv_if.sv
// ----------------------------
// muldiv channels
// val/rdy request and response links between router and units
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

// request channel, router to one unit
interface imuldiv_req_if;
  import imuldiv_pkg::*;

  logic     val;
  logic     rdy;
  operand_t a;
  operand_t b;
  fn_t      fn;

  modport router (output val, output a, output b, output fn, input rdy);

  // the multiplier has only one function, so no fn
  modport mul_unit (input val, input a, input b, output rdy);

  modport div_unit (input val, input a, input b, input fn, output rdy);

endinterface

// response channel, one unit back to the router
interface imuldiv_resp_if;
  import imuldiv_pkg::*;

  logic    val;
  logic    rdy;
  result_t result;

  modport unit (output val, output result, input rdy);

  modport router (input val, input result, output rdy);

endinterface

`default_nettype wire

// File: logic/int_mul_iterative.sv
// ----------------------------
// iterative multiplier
// signed shift-and-add on magnitudes, one bit per cycle
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_settings.svh"

module int_mul_iterative (
  input logic           clk,
  input logic           reset,
  imuldiv_req_if.mul_unit req,
  imuldiv_resp_if.unit    resp
);
  import imuldiv_pkg::*;

  // ----------------------------
  // control state
  // ----------------------------
  unit_state_t state;
  step_cnt_t   cnt;
  // corrected result is sitting in result_q
  logic        result_vld;

  // ----------------------------
  // datapath registers
  // ----------------------------
  // multiplicand, grows left over the steps
  result_t  mcand;
  // multiplier, consumed from the low end
  operand_t mplier;
  result_t  acc;
  // product sign
  logic     neg;
  result_t  result_q;

  operand_t a_mag;
  operand_t b_mag;
  logic     accept;
  logic     last_step;

  // magnitudes of the incoming operands
  always_comb begin
    a_mag = req.a[`IMULDIV_XLEN-1] ? operand_t'(~req.a + 1'b1) : req.a;
    b_mag = req.b[`IMULDIV_XLEN-1] ? operand_t'(~req.b + 1'b1) : req.b;
  end

  assign accept    = req.val && req.rdy;
  assign last_step = (cnt == step_cnt_t'(`IMULDIV_XLEN - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      cnt        <= '0;
      result_vld <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_CALC;
            cnt   <= '0;
          end
        end
        ST_CALC: begin
          // one step per cycle, XLEN steps in all
          if (last_step) begin
            state <= ST_DONE;
          end
          cnt <= step_cnt_t'(cnt + 1'b1);
        end
        ST_DONE: begin
          // first cycle registers the signed result, then wait for the sink
          if (!result_vld) begin
            result_vld <= 1'b1;
          end else if (resp.rdy) begin
            result_vld <= 1'b0;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg    <= req.a[`IMULDIV_XLEN-1] ^ req.b[`IMULDIV_XLEN-1];
    end else if (state == ST_CALC) begin
      // add when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if ((state == ST_DONE) && !result_vld) begin
      // sign fix, negate the magnitude product
      result_q <= neg ? result_t'(~acc + 1'b1) : acc;
    end
  end

  // only idle takes a new request
  assign req.rdy     = (state == ST_IDLE);
  assign resp.val    = result_vld;
  assign resp.result = result_q;

endmodule

`default_nettype wire

// File: logic/int_div_iterative.sv
// ----------------------------
// iterative divider
// restoring divide, signed or unsigned, result {rem, quot}
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_settings.svh"

module int_div_iterative (
  input logic           clk,
  input logic           reset,
  imuldiv_req_if.div_unit req,
  imuldiv_resp_if.unit    resp
);
  import imuldiv_pkg::*;

  // ----------------------------
  // control state
  // ----------------------------
  unit_state_t state;
  step_cnt_t   cnt;
  logic        result_vld;

  // ----------------------------
  // datapath registers
  // ----------------------------
  // holds dividend bits at first, quotient bits fill in from the right
  operand_t quo;
  // partial remainder
  operand_t rem;
  operand_t dvs;
  // original dividend, needed for the divide-by-zero result
  operand_t dvd_raw;
  logic     q_neg;
  logic     r_neg;
  logic     div_zero;
  result_t  result_q;

  logic     is_signed;
  logic     a_neg;
  logic     b_neg;
  operand_t a_mag;
  operand_t b_mag;
  logic     accept;
  logic     last_step;

  // one bit wider so the borrow shows up in the top bit
  logic [`IMULDIV_XLEN:0] rem_sh;
  logic [`IMULDIV_XLEN:0] diff;

  operand_t q_fix;
  operand_t r_fix;

  // only FN_DIV is signed, reserved code 3 falls through to unsigned
  assign is_signed = (req.fn == FN_DIV);
  assign a_neg     = is_signed && req.a[`IMULDIV_XLEN-1];
  assign b_neg     = is_signed && req.b[`IMULDIV_XLEN-1];

  always_comb begin
    a_mag = a_neg ? operand_t'(~req.a + 1'b1) : req.a;
    b_mag = b_neg ? operand_t'(~req.b + 1'b1) : req.b;
  end

  assign accept    = req.val && req.rdy;
  assign last_step = (cnt == step_cnt_t'(`IMULDIV_XLEN - 1));

  // bring down the next dividend bit and try the subtract
  always_comb begin
    rem_sh = {rem, quo[`IMULDIV_XLEN-1]};
    diff   = rem_sh - {1'b0, dvs};
  end

  // sign correction on the finished magnitudes
  always_comb begin
    q_fix = q_neg ? operand_t'(~quo + 1'b1) : quo;
    r_fix = r_neg ? operand_t'(~rem + 1'b1) : rem;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      cnt        <= '0;
      result_vld <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_CALC;
            cnt   <= '0;
          end
        end
        ST_CALC: begin
          if (last_step) begin
            state <= ST_DONE;
          end
          cnt <= step_cnt_t'(cnt + 1'b1);
        end
        ST_DONE: begin
          if (!result_vld) begin
            result_vld <= 1'b1;
          end else if (resp.rdy) begin
            result_vld <= 1'b0;
            state      <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      quo      <= a_mag;
      rem      <= '0;
      dvs      <= b_mag;
      dvd_raw  <= req.a;
      q_neg    <= a_neg ^ b_neg;
      // remainder takes the dividend's sign
      r_neg    <= a_neg;
      div_zero <= (req.b == '0);
    end else if (state == ST_CALC) begin
      // restore by keeping the shifted value when the subtract borrows
      if (!diff[`IMULDIV_XLEN]) begin
        rem <= diff[`IMULDIV_XLEN-1:0];
        quo <= {quo[`IMULDIV_XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_sh[`IMULDIV_XLEN-1:0];
        quo <= {quo[`IMULDIV_XLEN-2:0], 1'b0};
      end
    end else if ((state == ST_DONE) && !result_vld) begin
      // zero divisor gives all-ones quotient, dividend as remainder
      if (div_zero) begin
        result_q <= {dvd_raw, {`IMULDIV_XLEN{1'b1}}};
      end else begin
        result_q <= {r_fix, q_fix};
      end
    end
  end

  assign req.rdy     = (state == ST_IDLE);
  assign resp.val    = result_vld;
  assign resp.result = result_q;

endmodule

`default_nettype wire

// File: logic/imuldiv_router.sv
// ----------------------------
// muldiv router
// dispatch by function code, in-order response merge
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_router (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_val,
  output logic                  req_rdy,
  input  imuldiv_pkg::operand_t req_a,
  input  imuldiv_pkg::operand_t req_b,
  input  imuldiv_pkg::fn_t      req_fn,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  output imuldiv_pkg::result_t  resp_result,
  imuldiv_req_if.router         mul_req,
  imuldiv_req_if.router         div_req,
  imuldiv_resp_if.router        mul_resp,
  imuldiv_resp_if.router        div_resp
);
  import imuldiv_pkg::*;

  localparam int DEPTH = `IMULDIV_ORDER_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ----------------------------
  // order queue, tag 1 means divider
  // ----------------------------
  logic             tag_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic is_mul;
  logic full;
  logic empty;
  logic unit_rdy;
  logic head_div;
  logic push;
  logic pop;

  // everything that is not a multiply goes to the divider
  assign is_mul = (req_fn == FN_MUL);
  assign full   = (count == CNT_W'(DEPTH));
  assign empty  = (count == '0);

  assign unit_rdy = is_mul ? mul_req.rdy : div_req.rdy;
  assign req_rdy  = unit_rdy && !full;

  // val only toward the addressed unit, and only with room to log the order
  assign mul_req.val = req_val && is_mul && !full;
  assign div_req.val = req_val && !is_mul && !full;

  // both units see the same operands
  assign mul_req.a  = req_a;
  assign mul_req.b  = req_b;
  assign mul_req.fn = req_fn;
  assign div_req.a  = req_a;
  assign div_req.b  = req_b;
  assign div_req.fn = req_fn;

  // ----------------------------
  // response merge
  // ----------------------------
  assign head_div = tag_q[rd_ptr];

  assign resp_val    = !empty && (head_div ? div_resp.val : mul_resp.val);
  assign resp_result = head_div ? div_resp.result : mul_resp.result;

  // a finished unit behind the head just waits in its done state
  assign mul_resp.rdy = resp_rdy && !empty && !head_div;
  assign div_resp.rdy = resp_rdy && !empty && head_div;

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : PTR_W'(wr_ptr + 1'b1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : PTR_W'(rd_ptr + 1'b1);
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        count <= CNT_W'(count + 1'b1);
      end else if (pop && !push) begin
        count <= CNT_W'(count - 1'b1);
      end
    end
  end

  // tag storage
  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[wr_ptr] <= !is_mul;
    end
  end

endmodule

`default_nettype wire

// File: logic/imuldiv_unit.sv
// ----------------------------
// muldiv top level
// router plus one multiplier and one divider
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

module imuldiv_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_val,
  output logic                  req_rdy,
  input  imuldiv_pkg::operand_t req_a,
  input  imuldiv_pkg::operand_t req_b,
  input  imuldiv_pkg::fn_t      req_fn,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  output imuldiv_pkg::result_t  resp_result
);

  // one request and one response channel per unit
  imuldiv_req_if  mul_req_if ();
  imuldiv_req_if  div_req_if ();
  imuldiv_resp_if mul_resp_if ();
  imuldiv_resp_if div_resp_if ();

  imuldiv_router router (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .mul_req     (mul_req_if.router),
    .div_req     (div_req_if.router),
    .mul_resp    (mul_resp_if.router),
    .div_resp    (div_resp_if.router)
  );

  int_mul_iterative mul (
    .clk   (clk),
    .reset (reset),
    .req   (mul_req_if.mul_unit),
    .resp  (mul_resp_if.unit)
  );

  int_div_iterative div (
    .clk   (clk),
    .reset (reset),
    .req   (div_req_if.div_unit),
    .resp  (div_resp_if.unit)
  );

endmodule

`default_nettype wire

// File: tb/imuldiv_properties.sv
// ----------------------------
// muldiv handshake assertions
// val/rdy rules on the top-level ports of imuldiv_unit
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

module imuldiv_properties (
  input logic                  clk,
  input logic                  reset,
  input logic                  req_val,
  input logic                  req_rdy,
  input imuldiv_pkg::operand_t req_a,
  input imuldiv_pkg::operand_t req_b,
  input imuldiv_pkg::fn_t      req_fn,
  input logic                  resp_val,
  input logic                  resp_rdy,
  input imuldiv_pkg::result_t  resp_result
);

  // assertion failures so far
  int n_fail = 0;

  // a stalled request keeps val and its operands until the transfer
  req_hold: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=>
      (req_val && $stable(req_a) && $stable(req_b) && $stable(req_fn)))
    else begin
      $error("request val or data changed before the transfer");
      n_fail++;
    end

  // a stalled response keeps val and its result
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      $error("response val or result changed before the transfer");
      n_fail++;
    end

  // nothing comes out right after reset
  resp_quiet: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      n_fail++;
    end

endmodule

bind imuldiv_unit imuldiv_properties props_inst (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .req_a       (req_a),
  .req_b       (req_b),
  .req_fn      (req_fn),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

// File: tb/imuldiv_tb.sv
// ----------------------------
// muldiv testbench
// directed tests on the iterative mul/div top level
// ----------------------------

`timescale 1ns/1ns
`default_nettype none

module imuldiv_tb;
  import imuldiv_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 200;
  // request transfer edge to resp_val
  localparam int LATENCY    = 33;

  logic     clk;
  logic     reset;
  logic     req_val;
  logic     req_rdy;
  operand_t req_a;
  operand_t req_b;
  fn_t      req_fn;
  logic     resp_val;
  logic     resp_rdy;
  result_t  resp_result;

  // rising edge count that is read only at falling edges
  int cyc = 0;
  int n_checks = 0;
  int n_errors = 0;
  int seed = 37;

  imuldiv_unit imuldiv_unit_inst (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) cyc = cyc + 1;

  // hard stop in case a test never returns
  initial begin
    #200000;
    $display("run stopped at the time limit before all tests ended");
    $display("CHECKS FAILED");
    $finish;
  end

  // ------------------------------
  // reference arithmetic
  // ------------------------------
  function automatic result_t expect_mul(operand_t a, operand_t b);
    longint sa;
    longint sb;
    sa = $signed(a);
    sb = $signed(b);
    return result_t'(sa * sb);
  endfunction

  function automatic result_t expect_div(operand_t a, operand_t b, fn_t fn);
    int       sa;
    int       sb;
    operand_t q;
    operand_t r;
    sa = $signed(a);
    sb = $signed(b);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (fn == FN_DIV) begin
      // most negative over minus one wraps back to itself
      if (a == 32'h8000_0000 && sb == -1) begin
        q = a;
        r = '0;
      end else begin
        q = operand_t'(sa / sb);
        r = operand_t'(sa % sb);
      end
    end else begin
      q = a / b;
      r = a % b;
    end
    return {r, q};
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_result(input string name, input result_t got, input result_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // handshake helpers
  // ------------------------------
  // called and returning 1 ns after a rising edge
  task automatic send_req(input operand_t a, input operand_t b, input fn_t fn,
                          output int xfer_edge);
    int   waited;
    logic done;
    waited    = 0;
    done      = 1'b0;
    xfer_edge = -1;
    req_val   = 1'b1;
    req_a     = a;
    req_b     = b;
    req_fn    = fn;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      // ready seen mid-cycle means the transfer is on the next edge
      if (req_rdy) begin
        done      = 1'b1;
        xfer_edge = cyc + 1;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    req_val = 1'b0;
    if (!done) begin
      n_errors++;
      $display("timeout: request was never accepted by the DUT");
    end
  endtask

  task automatic get_resp(output result_t r, output int val_edge, output int xfer_edge);
    int   waited;
    logic done;
    waited    = 0;
    done      = 1'b0;
    r         = '0;
    val_edge  = -1;
    xfer_edge = -1;
    resp_rdy  = 1'b1;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clk);
      if (resp_val) begin
        done      = 1'b1;
        r         = resp_result;
        val_edge  = cyc;
        xfer_edge = cyc + 1;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    resp_rdy = 1'b0;
    if (!done) begin
      n_errors++;
      $display("timeout: no response came back from the DUT");
    end
  endtask

  // one request and its response, with result and latency checked
  task automatic run_op(input operand_t a, input operand_t b, input fn_t fn,
                        input result_t exp);
    int      x_edge;
    int      v_edge;
    int      d_edge;
    result_t r;
    send_req(a, b, fn, x_edge);
    get_resp(r, v_edge, d_edge);
    check_result("resp_result", r, exp);
    check_latency("resp_val latency", v_edge - x_edge, LATENCY);
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("test %-18s %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_state();
    int c0;
    int e0;
    c0 = n_checks;
    e0 = n_errors;
    @(negedge clk);
    check_bit("resp_val", resp_val, 1'b0);
    check_bit("req_rdy", req_rdy, 1'b1);
    @(posedge clk);
    #1;
    report_test("reset state", c0, e0);
  endtask

  task automatic signed_multiply();
    operand_t a_list [8] = '{32'd3, -32'd3, 32'd3, -32'd3,
                             32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'd0};
    operand_t b_list [8] = '{32'd5, 32'd5, -32'd5, -32'd5,
                             32'h8000_0000, 32'd1, -32'd1, -32'd7};
    operand_t a;
    operand_t b;
    int       c0;
    int       e0;
    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < 8; i++) begin
      run_op(a_list[i], b_list[i], FN_MUL, expect_mul(a_list[i], b_list[i]));
    end
    repeat (16) begin
      a = $random(seed);
      b = $random(seed);
      run_op(a, b, FN_MUL, expect_mul(a, b));
    end
    report_test("signed multiply", c0, e0);
  endtask

  task automatic divide_ops();
    operand_t a_list [6] = '{32'd100, -32'd100, 32'd100, -32'd100, 32'h8000_0000, 32'd7};
    operand_t b_list [6] = '{32'd7, 32'd7, -32'd7, -32'd7, -32'd1, 32'd100};
    operand_t a;
    operand_t b;
    fn_t      fn;
    int       c0;
    int       e0;
    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < 6; i++) begin
      run_op(a_list[i], b_list[i], FN_DIV, expect_div(a_list[i], b_list[i], FN_DIV));
      run_op(a_list[i], b_list[i], FN_DIVU, expect_div(a_list[i], b_list[i], FN_DIVU));
    end
    for (int i = 0; i < 8; i++) begin
      a  = $random(seed);
      b  = $random(seed);
      // every other divisor is a small signed value, so quotients get wide
      if (i % 2 == 1) begin
        b = {{20{b[11]}}, b[11:0]};
      end
      fn = (i < 4) ? FN_DIV : FN_DIVU;
      run_op(a, b, fn, expect_div(a, b, fn));
    end
    report_test("divide", c0, e0);
  endtask

  task automatic divide_by_zero();
    operand_t a_list [4] = '{32'd12345, 32'h8000_0000, 32'hffff_ffff, 32'd0};
    int       c0;
    int       e0;
    c0 = n_checks;
    e0 = n_errors;
    // quotient is all ones and remainder is the dividend
    for (int i = 0; i < 4; i++) begin
      run_op(a_list[i], '0, FN_DIV, {a_list[i], 32'hffff_ffff});
      run_op(a_list[i], '0, FN_DIVU, {a_list[i], 32'hffff_ffff});
    end
    report_test("divide by zero", c0, e0);
  endtask

  task automatic order_and_overlap();
    operand_t a1 = 32'd1000;
    operand_t b1 = -32'd3;
    operand_t a2 = 32'd999;
    operand_t b2 = 32'd10;
    operand_t a3 = -32'd77;
    operand_t b3 = 32'd77;
    result_t  r1;
    result_t  r2;
    result_t  r3;
    int       e1;
    int       e2;
    int       e3;
    int       v1;
    int       v2;
    int       v3;
    int       x1;
    int       x2;
    int       x3;
    int       c0;
    int       e0;
    c0 = n_checks;
    e0 = n_errors;
    send_req(a1, b1, FN_MUL, e1);
    send_req(a2, b2, FN_DIV, e2);
    check_latency("divide accept edge", e2 - e1, 1);
    // second multiply finds the multiplier busy
    req_val = 1'b1;
    req_a   = a3;
    req_b   = b3;
    req_fn  = FN_MUL;
    @(negedge clk);
    check_bit("req_rdy", req_rdy, 1'b0);
    @(posedge clk);
    #1;
    fork
      send_req(a3, b3, FN_MUL, e3);
      begin
        get_resp(r1, v1, x1);
        get_resp(r2, v2, x2);
        get_resp(r3, v3, x3);
      end
    join
    // responses in request order
    check_result("resp_result", r1, expect_mul(a1, b1));
    check_result("resp_result", r2, expect_div(a2, b2, FN_DIV));
    check_result("resp_result", r3, expect_mul(a3, b3));
    // divide ran alongside the multiply
    check_latency("divide resp_val latency", v2 - e2, LATENCY);
    check_bit("multiply held until first response", e3 > x1, 1'b1);
    report_test("order and overlap", c0, e0);
  endtask

  task automatic back_pressure();
    operand_t a = 32'hdead_beef;
    operand_t b = 32'h1234_5678;
    result_t  exp;
    result_t  held;
    result_t  r;
    logic     seen;
    int       waited;
    int       x_edge;
    int       v_edge;
    int       d_edge;
    int       c0;
    int       e0;
    c0     = n_checks;
    e0     = n_errors;
    exp    = expect_mul(a, b);
    held   = '0;
    seen   = 1'b0;
    waited = 0;
    send_req(a, b, FN_MUL, x_edge);
    while (!seen && waited < WAIT_LIMIT) begin
      @(negedge clk);
      if (resp_val) begin
        seen = 1'b1;
        held = resp_result;
      end
      waited++;
    end
    if (!seen) begin
      n_errors++;
      $display("timeout: no response appeared while resp_rdy was low");
    end
    check_result("resp_result", held, exp);
    // sink stays busy for 20 more cycles
    repeat (20) begin
      @(negedge clk);
      check_bit("resp_val", resp_val, 1'b1);
      check_result("resp_result", resp_result, held);
    end
    @(posedge clk);
    #1;
    get_resp(r, v_edge, d_edge);
    check_result("resp_result", r, exp);
    report_test("back-pressure", c0, e0);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req_a    = '0;
    req_b    = '0;
    req_fn   = FN_MUL;
    resp_rdy = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    reset_state();
    signed_multiply();
    divide_ops();
    divide_by_zero();
    order_and_overlap();
    back_pressure();
    // handshake assertion failures from the bound checker
    n_errors = n_errors + imuldiv_unit_inst.props_inst.n_fail;
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/imuldiv_pkg.sv
logic/imuldiv_if.sv
logic/int_mul_iterative.sv
logic/int_div_iterative.sv
logic/imuldiv_router.sv
logic/imuldiv_unit.sv
tb/imuldiv_properties.sv
tb/imuldiv_tb.sv
